/* verilog.f */
+incdir+include
logic/fb_pkg.sv
logic/video_timing.sv
logic/frame_ram.sv
logic/bus_arbiter.sv
logic/pixel_scanout.sv
logic/frame_buffer_top.sv
verif/tb_frame_buffer.sv

/* run_sim.sh */
#!/bin/sh
# build the frame buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_frame_buffer \
  -f verilog.f -o tb_frame_buffer

# the log decides pass or fail, not the exit code of the run
./obj_dir/tb_frame_buffer > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* verif/tb_frame_buffer.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module tb_frame_buffer
  import fb_pkg::*;
();

  localparam int WAIT_LIMIT = `FB_H_TOTAL * `FB_V_TOTAL + 16;  // a frame and a bit
  localparam int HOLD_LIMIT = 8;
  localparam int MEM_WORDS  = 1 << `FB_ADDR_W;
  localparam colour_t PAL_MODEL [0:3] = '{4'd0, 4'd1, 4'd4, 4'd7};

  logic        clk;
  logic        rst_n;
  ram_addr_t   host_addr;
  logic [15:0] host_wdata;
  logic        host_we;
  logic        host_re;
  logic        host_hold;
  logic [15:0] host_rdata;
  logic        host_rvalid;
  colour_t     rgb;
  logic        hsync;
  logic        vsync;

  logic [15:0] lfsr;
  fb_word_t    mem_model [0:MEM_WORDS-1];
  bit          known [0:MEM_WORDS-1];  // word written since reset
  ram_addr_t   held_q [$];             // held writes still to read back
  int          m_h, m_v;               // model raster in the current cycle
  int          d1_h, d1_v, d2_h, d2_v; // one and two cycles back
  bit          d1_ok, d2_ok;
  bit          scan_on;
  bit          timed_out;
  int          err_count, check_count, hold_count;

  frame_buffer_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_we     (host_we),
    .host_re     (host_re),
    .host_hold   (host_hold),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .rgb         (rgb),
    .hsync       (hsync),
    .vsync       (vsync)
  );

  always #50 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_h   <= 0;
      m_v   <= 0;
      d1_ok <= 1'b0;
      d2_ok <= 1'b0;
    end else begin
      d1_h  <= m_h;
      d1_v  <= m_v;
      d1_ok <= 1'b1;
      d2_h  <= d1_h;
      d2_v  <= d1_v;
      d2_ok <= d1_ok;
      if (m_h == `FB_H_TOTAL - 1) begin
        m_h <= 0;
        m_v <= (m_v == `FB_V_TOTAL - 1) ? 0 : m_v + 1;
      end else begin
        m_h <= m_h + 1;
      end
    end
  end

  // galois LFSR stepped once per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic bit hsync_at(input int h);
    return h >= `FB_HSYNC_START && h <= `FB_HSYNC_END;
  endfunction

  function automatic bit vsync_at(input int v);
    return v >= `FB_VSYNC_START && v <= `FB_VSYNC_END;
  endfunction

  function automatic bit shown_at(input int h, input int v);
    return h < `FB_H_ACTIVE && v < `FB_V_ACTIVE;
  endfunction

  // a fetch lands two cycles before the first pixel of a visible group
  function automatic bit fetch_at(input int h, input int v);
    int th;
    int tv;
    th = (h + 2) % `FB_H_TOTAL;
    tv = (h + 2 >= `FB_H_TOTAL) ? (v + 1) % `FB_V_TOTAL : v;
    return (th % 8 == 0) && shown_at(th, tv);
  endfunction

  function automatic colour_t colour_at(input int h, input int v);
    fb_word_t w;
    if (!shown_at(h, v))
      return 4'd0;  // blanking is black
    w = mem_model[ram_addr_t'(`FB_BASE + v * `FB_WORDS_PER_LINE + h / 8)];
    return PAL_MODEL[w.pix[3'(h % 8)]];
  endfunction

  task automatic check_word(input string name, input fb_word_t got, input fb_word_t exp);
    check_count++;
    if (got.raw !== exp.raw) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic check_colour(input string name, input colour_t got, input colour_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    err_count++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic note_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    timed_out = 1'b1;
  endtask

  task automatic report_counts();
    $display("%0d checks, %0d errors, %0d held host accesses", check_count, err_count,
             hold_count);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  task automatic wait_raster(input int h, input int v);
    int cnt;
    cnt = 0;
    while (!(m_h == h && m_v == v) && !timed_out) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT)
        note_timeout("a raster position");
    end
  endtask

  // one access from a falling edge to a falling edge
  task automatic host_access(input bit wr, input ram_addr_t addr, input logic [15:0] data,
                             output bit held);
    int       cnt;
    fb_word_t exp;
    held       = 1'b0;
    cnt        = 0;
    host_addr  = addr;
    host_wdata = data;
    host_we    = wr;
    host_re    = !wr;
    #1;
    check_bit("host_hold", host_hold, fetch_at(m_h, m_v));
    while (host_hold && !timed_out) begin
      held = 1'b1;
      @(negedge clk);
      #1;
      cnt++;
      if (cnt > HOLD_LIMIT)
        note_timeout("host_hold to fall");
      check_bit("host_rvalid", host_rvalid, 1'b0);  // a blocked access returns nothing
      check_bit("host_hold", host_hold, fetch_at(m_h, m_v));
    end
    exp = mem_model[addr];  // RAM word at the access
    @(negedge clk);
    if (wr) begin
      mem_model[addr] = data;
      known[addr]     = 1'b1;
      check_bit("host_rvalid", host_rvalid, 1'b0);  // writes return no data
    end else begin
      cnt = 0;
      while (!host_rvalid && !timed_out) begin
        @(negedge clk);
        cnt++;
        if (cnt > HOLD_LIMIT)
          note_timeout("host_rvalid");
      end
      if (cnt != 0)
        report_error("host_rvalid came later than one cycle after the read");
      check_word("host_rdata", fb_word_t'(host_rdata), exp);
    end
  endtask

  task automatic random_op();
    ram_addr_t   addr;
    bit          wr;
    bit          held;
    logic [15:0] data;
    addr = ram_addr_t'(rand_bits(9));  // 9 bits keep it below FB_BASE
    wr   = (rand_bits(1) != 16'd0) || !known[addr];
    data = rand_bits(16);
    host_access(wr, addr, data, held);
    if (held) begin
      hold_count++;
      if (wr)
        held_q.push_back(addr);
    end
  endtask

  task automatic host_idle();
    host_we = 1'b0;
    host_re = 1'b0;
  endtask

  task automatic monitor_outputs();
    forever begin
      @(negedge clk);
      if (rst_n) begin
        check_bit("hsync", hsync, d2_ok && hsync_at(d2_h));
        check_bit("vsync", vsync, d2_ok && vsync_at(d2_v));
        if (scan_on)
          check_colour("rgb", rgb, colour_at(d2_h, d2_v));
      end
    end
  endtask

  always @(posedge timed_out) begin
    report_counts();
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int        errs;
    int        n;
    ram_addr_t a;
    bit        held;
    clk        = 1'b0;
    rst_n      = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_we    = 1'b0;
    host_re    = 1'b0;
    lfsr       = 16'd209;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    fork
      begin
        errs = err_count;
        check_bit("host_hold", host_hold, 1'b0);
        check_bit("host_rvalid", host_rvalid, 1'b0);
        check_colour("rgb", rgb, 4'd0);
        check_bit("hsync", hsync, 1'b0);
        check_bit("vsync", vsync, 1'b0);
        finish_test("reset values", errs);

        errs = err_count;
        repeat (300) random_op();
        host_idle();
        finish_test("host write and read", errs);

        // fill the frame buffer while the raster is in vertical blanking
        errs = err_count;
        wait_raster(0, `FB_V_ACTIVE);
        for (n = 0; n < `FB_V_ACTIVE * `FB_WORDS_PER_LINE; n++)
          host_access(1'b1, ram_addr_t'(`FB_BASE + n), rand_bits(16), held);
        host_idle();
        scan_on = 1'b1;
        for (n = 0; n < 3; n++) begin
          @(negedge clk);
          wait_raster(0, 0);
        end
        finish_test("scanout and sync outputs", errs);

        errs       = err_count;
        hold_count = 0;
        wait_raster(0, 2);
        repeat (400) random_op();
        host_idle();
        if (hold_count == 0)
          report_error("no host access was held by a video fetch");
        while (held_q.size() > 0) begin
          a = held_q.pop_front();
          host_access(1'b0, a, 16'h0000, held);
        end
        host_idle();
        finish_test("contention", errs);
      end
      monitor_outputs();
    join_any
    report_counts();
    if (err_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* logic/frame_buffer_top.sv */
`timescale 1ns/10ps

module frame_buffer_top
  import fb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  ram_addr_t   host_addr,
  input  logic [15:0] host_wdata,
  input  logic        host_we,
  input  logic        host_re,
  output logic        host_hold,
  output logic [15:0] host_rdata,
  output logic        host_rvalid,
  output colour_t     rgb,
  output logic        hsync,
  output logic        vsync
);

  // raster from the sync generator
  hpos_t       hpos;
  vpos_t       vpos;
  logic        tim_hsync;
  logic        tim_vsync;
  logic        display_on;

  // video master to arbiter
  logic        vid_req;
  ram_addr_t   vid_addr;
  fb_word_t    vid_rdata;

  // arbiter to RAM
  ram_addr_t   ram_addr;
  logic [15:0] ram_wdata;
  logic        ram_we;
  logic [15:0] ram_rdata;

  video_timing timing_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .hsync      (tim_hsync),
    .vsync      (tim_vsync),
    .display_on (display_on),
    .hpos       (hpos),
    .vpos       (vpos)
  );

  pixel_scanout scanout_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .hpos       (hpos),
    .vpos       (vpos),
    .hsync      (tim_hsync),
    .vsync      (tim_vsync),
    .display_on (display_on),
    .vid_req    (vid_req),
    .vid_addr   (vid_addr),
    .vid_rdata  (vid_rdata),
    .rgb        (rgb),
    .hsync_out  (hsync),  // delayed to line up with rgb
    .vsync_out  (vsync)
  );

  bus_arbiter arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .vid_req     (vid_req),
    .vid_addr    (vid_addr),
    .vid_rdata   (vid_rdata),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_we     (host_we),
    .host_re     (host_re),
    .host_hold   (host_hold),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_we      (ram_we),
    .ram_rdata   (ram_rdata)
  );

  frame_ram ram_i (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .we    (ram_we),
    .rdata (ram_rdata)
  );

endmodule

/* logic/pixel_scanout.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module pixel_scanout
  import fb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  hpos_t     hpos,
  input  vpos_t     vpos,
  input  logic      hsync,
  input  logic      vsync,
  input  logic      display_on,
  output logic      vid_req,
  output ram_addr_t vid_addr,
  input  fb_word_t  vid_rdata,
  output colour_t   rgb,
  output logic      hsync_out,
  output logic      vsync_out
);

  localparam colour_t PALETTE [0:3] = '{4'd0, 4'd1, 4'd4, 4'd7};

  logic [7:0] next_h;      // position two cycles ahead
  vpos_t      fetch_line;
  logic [2:0] fetch_grp;   // word within the line
  logic       req_q;       // RAM data arrives this cycle
  fb_word_t   shreg;       // pixels of the current word
  pixel_t     pix_d1;
  logic       disp_d1;
  logic       hs_d1;
  logic       vs_d1;

  assign next_h = {1'b0, hpos} + 8'd2;

  // fetch two cycles ahead of the first pixel of each group
  always_comb begin
    fetch_line = vpos;
    fetch_grp  = next_h[5:3];
    vid_req    = 1'b0;
    if (hpos[2:0] == 3'd6) begin
      if (next_h == 8'(`FB_H_TOTAL)) begin
        // group 0 of the following line, wraps at frame end
        fetch_line = (vpos == vpos_t'(`FB_V_TOTAL - 1)) ? '0 : vpos + 1'b1;
        fetch_grp  = 3'd0;
        vid_req    = (fetch_line < vpos_t'(`FB_V_ACTIVE));
      end else begin
        vid_req = (next_h < 8'(`FB_H_ACTIVE)) && (vpos < vpos_t'(`FB_V_ACTIVE));
      end
    end
  end

  assign vid_addr = ram_addr_t'(`FB_BASE + `FB_WORDS_PER_LINE * fetch_line + fetch_grp);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      req_q <= 1'b0;
    else
      req_q <= vid_req;
  end

  // load on return, otherwise move the next pixel to the top
  always_ff @(posedge clk) begin
    if (req_q)
      shreg <= vid_rdata;
    else
      shreg.raw <= {shreg.raw[13:0], 2'b00};
  end

  // two stage output pipe, syncs follow the same delay
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_d1    <= '0;
      disp_d1   <= 1'b0;
      hs_d1     <= 1'b0;
      vs_d1     <= 1'b0;
      rgb       <= '0;
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
    end else begin
      pix_d1    <= shreg.pix[0];
      disp_d1   <= display_on;
      hs_d1     <= hsync;
      vs_d1     <= vsync;
      rgb       <= disp_d1 ? PALETTE[pix_d1] : '0;  // black in blanking
      hsync_out <= hs_d1;
      vsync_out <= vs_d1;
    end
  end

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter
  import fb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // video master, always wins
  input  logic        vid_req,
  input  ram_addr_t   vid_addr,
  output fb_word_t    vid_rdata,
  // host master
  input  ram_addr_t   host_addr,
  input  logic [15:0] host_wdata,
  input  logic        host_we,
  input  logic        host_re,
  output logic        host_hold,
  output logic [15:0] host_rdata,
  output logic        host_rvalid,
  // RAM port
  output ram_addr_t   ram_addr,
  output logic [15:0] ram_wdata,
  output logic        ram_we,
  input  logic [15:0] ram_rdata
);

  logic host_go;    // host owns the port this cycle
  logic host_rd;    // host read issued this cycle
  logic vid_rd_q;   // read data next cycle belongs to video
  logic host_rd_q;  // read data next cycle belongs to host

  assign host_go   = !vid_req && (host_we || host_re);
  assign host_rd   = host_go && host_re && !host_we;  // write wins if both are set
  assign host_hold = vid_req && (host_we || host_re);

  assign ram_addr  = vid_req ? vid_addr : host_addr;
  assign ram_wdata = host_wdata;
  assign ram_we    = host_go && host_we;

  // remember the owner of each read for the return cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vid_rd_q  <= 1'b0;
      host_rd_q <= 1'b0;
    end else begin
      vid_rd_q  <= vid_req;
      host_rd_q <= host_rd;
    end
  end

  // steer the returned word to its owner only
  assign vid_rdata   = vid_rd_q ? fb_word_t'(ram_rdata) : '0;
  assign host_rdata  = host_rd_q ? ram_rdata : '0;
  assign host_rvalid = host_rd_q;

endmodule

/* logic/frame_ram.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module frame_ram (
  input  logic                  clk,
  input  logic [`FB_ADDR_W-1:0] addr,
  input  logic [15:0]           wdata,
  input  logic                  we,
  output logic [15:0]           rdata
);

  localparam int DEPTH = 1 << `FB_ADDR_W;

  logic [15:0] mem [0:DEPTH-1];

  // single port, write and read share the address
  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
  end

  // read is registered, data shows one cycle after addr
  // a write cycle returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* logic/video_timing.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module video_timing
  import fb_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output logic  hsync,
  output logic  vsync,
  output logic  display_on,
  output hpos_t hpos,
  output vpos_t vpos
);

  logic h_wrap;  // last cycle of a line
  logic v_wrap;  // last line of a frame

  assign h_wrap = (hpos == hpos_t'(`FB_H_TOTAL - 1));
  assign v_wrap = (vpos == vpos_t'(`FB_V_TOTAL - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else begin
      if (h_wrap) begin
        hpos <= '0;
        if (v_wrap)
          vpos <= '0;
        else
          vpos <= vpos + 1'b1;  // next line
      end else begin
        hpos <= hpos + 1'b1;
      end
    end
  end

  // decoded straight from the counters, active high pulses
  assign hsync = (hpos >= hpos_t'(`FB_HSYNC_START)) &&
                 (hpos <= hpos_t'(`FB_HSYNC_END));
  assign vsync = (vpos >= vpos_t'(`FB_VSYNC_START)) &&
                 (vpos <= vpos_t'(`FB_VSYNC_END));

  assign display_on = (hpos < hpos_t'(`FB_H_ACTIVE)) &&
                      (vpos < vpos_t'(`FB_V_ACTIVE));

endmodule

/* logic/fb_pkg.sv */
`include "fb_cfg.svh"

package fb_pkg;

  typedef logic [1:0] pixel_t;   // palette index
  typedef logic [3:0] colour_t;  // rgb level on the pins

  typedef logic [`FB_ADDR_W-1:0] ram_addr_t;

  // raster counters
  typedef logic [6:0] hpos_t;
  typedef logic [4:0] vpos_t;

  // one frame word, seen as raw data by the host and RAM,
  // or as eight pixels by the scanout
  // pix[0] sits in bits 15:14 and is shown first
  typedef union packed {
    logic [15:0]        raw;
    pixel_t [0:7]       pix;
  } fb_word_t;

endpackage

/* include/fb_cfg.svh */
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// raster is kept tiny so a simulation sees many frames

// horizontal timing, in clock cycles
`define FB_H_ACTIVE       64
`define FB_H_TOTAL        96
`define FB_HSYNC_START    72
`define FB_HSYNC_END      79

// vertical timing, in lines
`define FB_V_ACTIVE       24
`define FB_V_TOTAL        30
`define FB_VSYNC_START    26
`define FB_VSYNC_END      27

// frame RAM
`define FB_ADDR_W         10   // 1024 words of 16 bits
`define FB_BASE           512  // word address of pixel word 0

// 8 pixels of 2 bits per word
`define FB_WORDS_PER_LINE 8

`endif
